// File: logic/bus_pkg.sv
////////////////////////////////////////////////////////////
// Register bus types between the SPI target and reg file
////////////////////////////////////////////////////////////
`default_nettype none
`include "subsystem_macros.svh"

package bus_pkg;

    typedef logic [`SUB_ADDR_WIDTH-1:0] reg_addr_t;     // Register address
    typedef logic [`SUB_DATA_WIDTH-1:0] reg_data_t;     // Register data

    // One-cycle strobes, no handshake
    typedef struct packed {
        logic      write_en;                            // Write strobe
        logic      read_en;                             // Read strobe
        reg_addr_t address;                             // Valid with either strobe
        reg_data_t wr_data;                             // Valid with write_en
    } reg_bus_t;

    // Phases of the two-byte SPI frame
    typedef enum logic [1:0] {
        COMMAND,                                        // Shifting in command byte
        WRITE_DATA,                                     // Shifting in write data
        READ_DATA,                                      // Shifting out read data
        IGNORE                                          // Extra bits until cs_n rises
    } spi_state_t;

endpackage

`default_nettype wire

// File: logic/fpga_subsystem.sv
////////////////////////////////////////////////////////////
// Motor subsystem top: SPI registers, tick divider, 8 PWMs
// Drive tick every 32 clocks, servo tick every 1024 clocks
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "subsystem_macros.svh"

module fpga_subsystem (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        spi_clock,
    input  logic                        cs_n,
    input  logic                        mosi,
    output logic                        miso,
    output logic [`SUB_MOTOR_COUNT-1:0] sd_pwm,       // Drive motor PWM
    output logic [`SUB_MOTOR_COUNT-1:0] servo_pwm,    // Arm servo PWM
    output logic                        status_pi,
    output logic                        status_ps4,
    output logic                        status_debug
);

    bus_pkg::reg_bus_t                           bus;
    bus_pkg::reg_data_t                          rd_data;
    motor_pkg::drive_cmd_t [`SUB_MOTOR_COUNT-1:0] drive_cmd;
    motor_pkg::pwm_ratio_t [`SUB_MOTOR_COUNT-1:0] drive_ratio;
    motor_pkg::pwm_ratio_t [`SUB_MOTOR_COUNT-1:0] servo_position;
    logic [`SUB_MOTOR_COUNT-1:0]                 servo_enable;
    motor_pkg::led_cmd_t                         led_cmd;
    logic [`SUB_DIV_WIDTH-1:0]                   div_count;
    logic [`SUB_DIV_WIDTH-1:0]                   div_next;
    logic                                        drive_tick;
    logic                                        servo_tick;

    ////////////////////////////////////////////////////////////
    // Tick divider
    ////////////////////////////////////////////////////////////
    assign div_next = div_count + 1'b1;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_count  <= '0;
            drive_tick <= 1'b0;
            servo_tick <= 1'b0;
        end else begin
            div_count  <= div_next;
            // Pulse whenever the tick bit toggles
            drive_tick <= div_next[`SUB_DRIVE_TICK_BIT] ^ div_count[`SUB_DRIVE_TICK_BIT];
            servo_tick <= div_next[`SUB_SERVO_TICK_BIT] ^ div_count[`SUB_SERVO_TICK_BIT];
        end
    end

    spi_target u_spi (
        .clock     (clock),
        .reset_n   (reset_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .rd_data   (rd_data),
        .bus       (bus)
    );

    reg_file u_regs (
        .clock          (clock),
        .reset_n        (reset_n),
        .bus            (bus),
        .rd_data        (rd_data),
        .drive_cmd      (drive_cmd),
        .servo_position (servo_position),
        .servo_enable   (servo_enable),
        .led_cmd        (led_cmd)
    );

    ////////////////////////////////////////////////////////////
    // PWM channels
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `SUB_MOTOR_COUNT; i++) begin : g_pwm
        assign drive_ratio[i] = {1'b0, drive_cmd[i].speed, 2'b00};   // Speed x 4

        pwm_channel u_drive (
            .clock      (clock),
            .reset_n    (reset_n),
            .tick       (drive_tick),
            .enable     (drive_cmd[i].enable),
            .ratio      (drive_ratio[i]),
            .pwm_signal (sd_pwm[i])
        );

        pwm_channel u_servo (
            .clock      (clock),
            .reset_n    (reset_n),
            .tick       (servo_tick),
            .enable     (servo_enable[i]),
            .ratio      (servo_position[i]),
            .pwm_signal (servo_pwm[i])
        );
    end

    // LED test mode forces pi / ps4 on and shows motor_hot
    assign status_pi    = led_cmd.test_enable | led_cmd.pi_connected;
    assign status_ps4   = led_cmd.test_enable | led_cmd.ps4_connected;
    assign status_debug = led_cmd.test_enable ? led_cmd.motor_hot : 1'b1;

endmodule

`default_nettype wire

// File: logic/motor_pkg.sv
////////////////////////////////////////////////////////////
// PWM ratio and motor / LED command types
// Ratios are high time out of a 256 tick period
////////////////////////////////////////////////////////////
`default_nettype none

package motor_pkg;

    typedef logic [7:0] pwm_ratio_t;                    // High ticks per period
    typedef logic [4:0] drive_speed_t;                  // Drive speed, ratio / 4

    // Register bit 7 enable, bits 4:0 speed
    typedef struct packed {
        logic         enable;
        drive_speed_t speed;
    } drive_cmd_t;

    // Register bits 0 to 3 in field order
    typedef struct packed {
        logic test_enable;                              // Bit 0, LED test mode
        logic pi_connected;                             // Bit 1
        logic ps4_connected;                            // Bit 2
        logic motor_hot;                                // Bit 3, shown in test mode
    } led_cmd_t;

endpackage

`default_nettype wire

// File: logic/pwm_channel.sv
////////////////////////////////////////////////////////////
// 8-bit PWM, 256 ticks per period, output registered
// New ratio and enable take effect at the period start
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pwm_channel (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  tick,
    input  logic                  enable,
    input  motor_pkg::pwm_ratio_t ratio,
    output logic                  pwm_signal
);

    motor_pkg::pwm_ratio_t count;                       // Ticks into the period
    motor_pkg::pwm_ratio_t ratio_q;                     // Ratio for this period
    logic                  enable_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count      <= '0;
            ratio_q    <= '0;
            enable_q   <= 1'b0;
            pwm_signal <= 1'b0;
        end else begin
            if (tick) begin
                count <= count + 8'd1;                  // Wraps after 256 ticks
                if (count == '0) begin
                    ratio_q  <= ratio;                  // Period boundary update
                    enable_q <= enable;
                end
            end
            pwm_signal <= enable_q && (count < ratio_q);
        end
    end

    ratio_at_boundary: assert property (@(posedge clock) disable iff (!reset_n)
        $changed(ratio_q) |-> $past(tick && count == '0))
        else $error("pwm_channel: ratio changed inside a period");

endmodule

`default_nettype wire

// File: logic/reg_file.sv
////////////////////////////////////////////////////////////
// Control registers with address decode and read mux
// Writes to ID and unmapped addresses are dropped
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "subsystem_macros.svh"

module reg_file (
    input  logic                                        clock,
    input  logic                                        reset_n,
    input  bus_pkg::reg_bus_t                           bus,
    output bus_pkg::reg_data_t                          rd_data,
    output motor_pkg::drive_cmd_t [`SUB_MOTOR_COUNT-1:0] drive_cmd,
    output motor_pkg::pwm_ratio_t [`SUB_MOTOR_COUNT-1:0] servo_position,
    output logic [`SUB_MOTOR_COUNT-1:0]                 servo_enable,
    output motor_pkg::led_cmd_t                         led_cmd
);

    logic [`SUB_MOTOR_COUNT-1:0] drive_hit;             // Address decode per channel
    logic [`SUB_MOTOR_COUNT-1:0] servo_hit;
    bus_pkg::reg_data_t          read_value;

    always_comb begin
        for (int i = 0; i < `SUB_MOTOR_COUNT; i++) begin
            drive_hit[i] = bus.address == bus_pkg::reg_addr_t'(`SUB_ADDR_DRIVE0 + i);
            servo_hit[i] = bus.address == bus_pkg::reg_addr_t'(`SUB_ADDR_SERVO0 + i);
        end
    end

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            drive_cmd      <= '0;
            servo_position <= '0;
            servo_enable   <= '0;
            led_cmd        <= '0;
        end else if (bus.write_en) begin
            for (int i = 0; i < `SUB_MOTOR_COUNT; i++) begin
                if (drive_hit[i]) begin
                    drive_cmd[i].enable <= bus.wr_data[7];
                    drive_cmd[i].speed  <= bus.wr_data[4:0];   // Bits 6:5 dropped
                end
                if (servo_hit[i]) begin
                    servo_position[i] <= bus.wr_data;
                end
            end
            if (bus.address == `SUB_ADDR_SERVO_EN) begin
                servo_enable <= bus.wr_data[`SUB_MOTOR_COUNT-1:0];
            end
            if (bus.address == `SUB_ADDR_LED) begin
                led_cmd.test_enable   <= bus.wr_data[0];
                led_cmd.pi_connected  <= bus.wr_data[1];
                led_cmd.ps4_connected <= bus.wr_data[2];
                led_cmd.motor_hot     <= bus.wr_data[3];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read mux, registered on read_en
    ////////////////////////////////////////////////////////////
    always_comb begin
        read_value = '0;                                // Unmapped reads 0
        for (int i = 0; i < `SUB_MOTOR_COUNT; i++) begin
            if (drive_hit[i]) begin
                read_value = {drive_cmd[i].enable, 2'b00, drive_cmd[i].speed};
            end
            if (servo_hit[i]) begin
                read_value = servo_position[i];
            end
        end
        if (bus.address == `SUB_ADDR_SERVO_EN) begin
            read_value = bus_pkg::reg_data_t'(servo_enable);
        end
        if (bus.address == `SUB_ADDR_LED) begin
            read_value = {4'b0000, led_cmd.motor_hot, led_cmd.ps4_connected,
                          led_cmd.pi_connected, led_cmd.test_enable};
        end
        if (bus.address == `SUB_ADDR_ID) begin
            read_value = `SUB_ID_VALUE;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= read_value;                      // Held until next read
        end
    end

    single_write: assert property (@(posedge clock) disable iff (!reset_n)
        bus.write_en |=> !bus.write_en)
        else $error("reg_file: write_en high on consecutive clocks");

endmodule

`default_nettype wire

// File: logic/spi_target.sv
////////////////////////////////////////////////////////////
// SPI mode 0 target, 16-bit frame: command byte then data
// spi_clock high and low time must be at least 8 clocks
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module spi_target (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               spi_clock,
    input  logic               cs_n,
    input  logic               mosi,
    output logic               miso,
    input  bus_pkg::reg_data_t rd_data,
    output bus_pkg::reg_bus_t  bus
);

    logic [2:0]          sync_a;                        // {spi_clock, cs_n, mosi}
    logic [2:0]          sync_b;                        // Second stage
    logic                sclk_prev;                     // For edge detect
    logic                sclk_rise;
    logic                sclk_fall;
    logic                cs_idle;
    logic [3:0]          bit_count;                     // Rising edges in frame
    logic                load_tx;                       // rd_data valid this cycle
    bus_pkg::spi_state_t state;
    bus_pkg::reg_data_t  rx_shift;
    bus_pkg::reg_data_t  rx_byte;                       // Shift value incl. current bit
    bus_pkg::reg_data_t  tx_shift;

    ////////////////////////////////////////////////////////////
    // Pin synchronizer and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sync_a    <= 3'b010;                        // cs_n idles high
            sync_b    <= 3'b010;
            sclk_prev <= 1'b0;
        end else begin
            sync_a    <= {spi_clock, cs_n, mosi};
            sync_b    <= sync_a;
            sclk_prev <= sync_b[2];
        end
    end

    assign sclk_rise = sync_b[2] & ~sclk_prev;
    assign sclk_fall = ~sync_b[2] & sclk_prev;
    assign cs_idle   = sync_b[1];
    assign rx_byte   = {rx_shift[6:0], sync_b[0]};      // MSB first

    // Data shifters
    always_ff @(posedge clock) begin
        if (sclk_rise) begin
            rx_shift <= rx_byte;
        end
        if (load_tx) begin
            tx_shift <= rd_data;                        // Before first falling edge
        end else if (sclk_fall && state == bus_pkg::READ_DATA) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM and register strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= bus_pkg::COMMAND;
            bit_count <= '0;
            load_tx   <= 1'b0;
            miso      <= 1'b0;
            bus       <= '0;
        end else begin
            bus.read_en  <= 1'b0;                       // Strobes last one clock
            bus.write_en <= 1'b0;
            load_tx      <= bus.read_en;                // reg_file answers next clock
            if (cs_idle) begin
                state     <= bus_pkg::COMMAND;          // Abort / restart frame
                bit_count <= '0;
                miso      <= 1'b0;
            end else if (sclk_rise) begin
                bit_count <= bit_count + 4'd1;
                case (state)
                    bus_pkg::COMMAND: begin
                        if (bit_count == 4'd7) begin
                            bus.address <= rx_byte[5:0];
                            if (rx_byte[7]) begin
                                state <= bus_pkg::WRITE_DATA;
                            end else begin
                                state       <= bus_pkg::READ_DATA;
                                bus.read_en <= 1'b1;    // After 8th rising edge
                            end
                        end
                    end
                    bus_pkg::WRITE_DATA: begin
                        if (bit_count == 4'd15) begin
                            state        <= bus_pkg::IGNORE;
                            bus.write_en <= 1'b1;       // After 16th rising edge
                            bus.wr_data  <= rx_byte;
                        end
                    end
                    bus_pkg::READ_DATA: begin
                        if (bit_count == 4'd15) begin
                            state <= bus_pkg::IGNORE;
                        end
                    end
                    default: begin
                        state <= bus_pkg::IGNORE;       // Wait for cs_n
                    end
                endcase
            end else if (sclk_fall) begin
                miso <= (state == bus_pkg::READ_DATA) & tx_shift[7];
            end
        end
    end

    strobe_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(bus.read_en && bus.write_en))
        else $error("spi_target: read and write strobes together");

endmodule

`default_nettype wire

// File: logic/subsystem_macros.svh
////////////////////////////////////////////////////////////
// Widths, register map and tick divider of the subsystem
// Tick bits must stay below SUB_DIV_WIDTH
////////////////////////////////////////////////////////////
`ifndef SUBSYSTEM_MACROS_SVH
`define SUBSYSTEM_MACROS_SVH

`define SUB_ADDR_WIDTH      6           // Register address bits
`define SUB_DATA_WIDTH      8           // Register data bits
`define SUB_MOTOR_COUNT     4           // Drive and servo channels each
`define SUB_DIV_WIDTH       11          // Tick divider counter
`define SUB_DRIVE_TICK_BIT  5           // Toggles every 32 clocks
`define SUB_SERVO_TICK_BIT  10          // Toggles every 1024 clocks

// Register map
`define SUB_ADDR_DRIVE0     6'h00       // Drive 0..3 at 0x00..0x03
`define SUB_ADDR_SERVO0     6'h04       // Servo 0..3 at 0x04..0x07
`define SUB_ADDR_SERVO_EN   6'h08       // One enable bit per servo
`define SUB_ADDR_LED        6'h09       // LED control bits 3:0
`define SUB_ADDR_ID         6'h3F       // Read only
`define SUB_ID_VALUE        8'hA5

`endif

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the pass line

cd "$(dirname "$0")" || exit 1
LOG=sim_run.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpga_subsystem -f verilog.f -o tb_fpga_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fpga_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi

// File: sim/tb_spi_tasks.svh
////////////////////////////////////////////////////////////
// SPI host, PWM measurement and compare tasks of the testbench
// Included inside the testbench module after its signals
////////////////////////////////////////////////////////////
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// Inputs change a short delay after the rising edge
task automatic wait_clocks(input int count);
    repeat (count) @(posedge clock);
    #DRIVE_DELAY;
endtask

////////////////////////////////////////////////////////////
// SPI mode 0 host with 16-bit frames MSB first
////////////////////////////////////////////////////////////
task automatic spi_frame(input logic [15:0] frame, output bus_pkg::reg_data_t rx);
    rx        = '0;
    cs_n      = 1'b0;
    for (int i = 15; i >= 0; i--) begin
        spi_clock = 1'b0;
        mosi      = frame[i];                           // Set up on low phase
        wait_clocks(SPI_HALF);
        if (i < 8) begin
            rx = {rx[6:0], miso};                       // Target drove it on falling edge
        end
        spi_clock = 1'b1;                               // Target samples here
        wait_clocks(SPI_HALF);
    end
    spi_clock = 1'b0;
    wait_clocks(SPI_HALF);
    cs_n = 1'b1;                                        // End of frame
    mosi = 1'b0;
    wait_clocks(SPI_HALF);
endtask

task automatic spi_write(input bus_pkg::reg_addr_t addr, input bus_pkg::reg_data_t data);
    bus_pkg::reg_data_t unused;
    logic               spare;
    spare = 1'($random(seed));                          // Command bit 6 is don't care
    spi_frame({1'b1, spare, addr, data}, unused);
    model_write(addr, data);
endtask

task automatic spi_read(input bus_pkg::reg_addr_t addr, output bus_pkg::reg_data_t data);
    spi_frame({2'b00, addr, 8'h00}, data);
endtask

// High clocks over 256 ticks of all four channels of one group
task automatic measure_ratio(input logic servo,
        output motor_pkg::pwm_ratio_t [`SUB_MOTOR_COUNT-1:0] ratio);
    int                          spacing;
    int                          high_count [`SUB_MOTOR_COUNT];
    logic [`SUB_MOTOR_COUNT-1:0] level;
    spacing = servo ? SERVO_SPACING : DRIVE_SPACING;
    foreach (high_count[i]) begin
        high_count[i] = 0;
    end
    repeat (TICKS_PER_PERIOD * spacing) begin
        wait_clocks(1);
        level = servo ? servo_pwm : sd_pwm;
        for (int i = 0; i < `SUB_MOTOR_COUNT; i++) begin
            high_count[i] += int'(level[i]);
        end
    end
    for (int i = 0; i < `SUB_MOTOR_COUNT; i++) begin
        ratio[i] = motor_pkg::pwm_ratio_t'(high_count[i] / spacing);
    end
endtask

////////////////////////////////////////////////////////////
// Compare tasks that stop at the first mismatch
////////////////////////////////////////////////////////////
task automatic check_data(input string name, input bus_pkg::reg_data_t expected,
        input bus_pkg::reg_data_t actual);
    if (actual !== expected) begin
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "register data mismatch");
    end
endtask

task automatic check_ratio(input string name, input motor_pkg::pwm_ratio_t expected,
        input motor_pkg::pwm_ratio_t actual);
    if (actual !== expected) begin
        $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "PWM ratio mismatch");
    end
endtask

task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("** Error %s: expected %b, actual %b", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "output level mismatch");
    end
endtask

`endif

// File: sim/tb_fpga_subsystem.sv
////////////////////////////////////////////////////////////
// Testbench of the motor subsystem, driven over SPI only
// Servo passes dominate the run, about 1.1M clocks
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "subsystem_macros.svh"

module tb_fpga_subsystem;

    localparam int     DRIVE_DELAY      = 10;                       // ns after rising edge
    localparam int     SPI_HALF         = 10;                       // Clocks per SPI phase
    localparam int     TICKS_PER_PERIOD = 256;
    localparam int     DRIVE_SPACING    = 1 << `SUB_DRIVE_TICK_BIT;
    localparam int     SERVO_SPACING    = 1 << `SUB_SERVO_TICK_BIT;
    localparam longint WATCHDOG_NS      = 64'd400_000_000;          // ~4M clocks at 100 ns
    localparam int     KIND_DATA        = 0;
    localparam int     KIND_RATIO       = 1;
    localparam int     KIND_LEVEL       = 2;

    logic                        clock;
    logic                        reset_n;
    logic                        spi_clock;
    logic                        cs_n;
    logic                        mosi;
    logic                        miso;
    logic [`SUB_MOTOR_COUNT-1:0] sd_pwm;
    logic [`SUB_MOTOR_COUNT-1:0] servo_pwm;
    logic                        status_pi;
    logic                        status_ps4;
    logic                        status_debug;

    integer             seed = 15564;
    bus_pkg::reg_data_t reg_model [0:63];                           // Written values
    int                 kind_q [$];                                 // Pending comparisons
    string              name_q [$];
    logic [7:0]         exp_q [$];
    logic [7:0]         act_q [$];
    int                 checks_posted = 0;
    int                 checks_done   = 0;

    `include "tb_spi_tasks.svh"

    fpga_subsystem dut (
        .clock        (clock),
        .reset_n      (reset_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .sd_pwm       (sd_pwm),
        .servo_pwm    (servo_pwm),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Register model and expected values
    ////////////////////////////////////////////////////////////
    function automatic void model_write(input bus_pkg::reg_addr_t addr,
            input bus_pkg::reg_data_t data);
        if (addr <= `SUB_ADDR_LED) begin                            // Writable block 0x00..0x09
            reg_model[addr] = data;
        end
    endfunction

    function automatic bus_pkg::reg_data_t expected_read(input bus_pkg::reg_addr_t addr);
        if (addr == `SUB_ADDR_ID) return `SUB_ID_VALUE;
        if (addr < `SUB_ADDR_SERVO0) return reg_model[addr] & 8'h9F;   // Enable and speed
        if (addr < `SUB_ADDR_SERVO_EN) return reg_model[addr];         // Servo position
        if (addr == `SUB_ADDR_SERVO_EN || addr == `SUB_ADDR_LED) begin
            return reg_model[addr] & 8'h0F;
        end
        return 8'h00;                                               // Unmapped
    endfunction

    function automatic motor_pkg::pwm_ratio_t expected_ratio(input logic servo, input int ch);
        bus_pkg::reg_data_t value;
        if (servo) begin
            value = reg_model[`SUB_ADDR_SERVO0 + ch];
            return reg_model[`SUB_ADDR_SERVO_EN][ch] ? value : 8'd0;
        end
        value = reg_model[`SUB_ADDR_DRIVE0 + ch];
        return value[7] ? motor_pkg::pwm_ratio_t'(int'(value[4:0]) * 4) : 8'd0;
    endfunction

    // {status_pi, status_ps4, status_debug}
    function automatic logic [2:0] expected_leds();
        bus_pkg::reg_data_t led;
        led = reg_model[`SUB_ADDR_LED];
        if (led[0]) return {1'b1, 1'b1, led[3]};                   // Test mode
        return {led[1], led[2], 1'b1};
    endfunction

    task automatic post_check(input int kind, input string name, input logic [7:0] expected,
            input logic [7:0] actual);
        kind_q.push_back(kind);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        checks_posted++;
    endtask

    task automatic post_leds(input string step);
        logic [2:0] leds;
        leds = expected_leds();
        post_check(KIND_LEVEL, {step, " status_pi"}, {7'd0, leds[2]}, {7'd0, status_pi});
        post_check(KIND_LEVEL, {step, " status_ps4"}, {7'd0, leds[1]}, {7'd0, status_ps4});
        post_check(KIND_LEVEL, {step, " status_debug"}, {7'd0, leds[0]}, {7'd0, status_debug});
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        bus_pkg::reg_data_t                           rd;
        bus_pkg::reg_data_t                           wr;
        motor_pkg::pwm_ratio_t [`SUB_MOTOR_COUNT-1:0] measured;
        reset_n   = 1'b0;
        spi_clock = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        foreach (reg_model[a]) begin
            reg_model[a] = '0;
        end
        repeat (10) @(posedge clock);
        #DRIVE_DELAY reset_n = 1'b1;
        wait_clocks(4);

        // Reset state
        for (int ch = 0; ch < `SUB_MOTOR_COUNT; ch++) begin
            post_check(KIND_LEVEL, $sformatf("reset sd_pwm[%0d]", ch), 8'd0, {7'd0, sd_pwm[ch]});
            post_check(KIND_LEVEL, $sformatf("reset servo_pwm[%0d]", ch), 8'd0,
                       {7'd0, servo_pwm[ch]});
        end
        post_leds("reset");
        for (int a = 0; a < 64; a++) begin
            spi_read(6'(a), rd);
            post_check(KIND_DATA, $sformatf("reset read 0x%02h", a), expected_read(6'(a)), rd);
        end

        // Register access, ID and unmapped writes included
        repeat (3) begin
            for (int a = 0; a < 64; a++) begin
                spi_write(6'(a), bus_pkg::reg_data_t'($random(seed)));
            end
            for (int a = 0; a < 64; a++) begin
                spi_read(6'(a), rd);
                post_check(KIND_DATA, $sformatf("readback 0x%02h", a), expected_read(6'(a)), rd);
            end
        end

        // Drive channels, pass 1 disables the even ones
        for (int pass = 0; pass < 2; pass++) begin
            for (int ch = 0; ch < `SUB_MOTOR_COUNT; ch++) begin
                wr    = bus_pkg::reg_data_t'($random(seed));
                wr[7] = (pass == 0) || (ch % 2 == 1);
                spi_write(6'(`SUB_ADDR_DRIVE0 + ch), wr);
            end
            wait_clocks((TICKS_PER_PERIOD + 1) * DRIVE_SPACING);   // New ratio latched
            measure_ratio(1'b0, measured);
            for (int ch = 0; ch < `SUB_MOTOR_COUNT; ch++) begin
                post_check(KIND_RATIO, $sformatf("drive %0d pass %0d", ch, pass),
                           expected_ratio(1'b0, ch), measured[ch]);
            end
        end

        // Servo channels, same pattern of enables
        for (int pass = 0; pass < 2; pass++) begin
            for (int ch = 0; ch < `SUB_MOTOR_COUNT; ch++) begin
                spi_write(6'(`SUB_ADDR_SERVO0 + ch), bus_pkg::reg_data_t'($random(seed)));
            end
            wr      = bus_pkg::reg_data_t'($random(seed));         // Upper bits ignored
            wr[3:0] = (pass == 0) ? 4'b1111 : 4'b1010;
            spi_write(`SUB_ADDR_SERVO_EN, wr);
            wait_clocks((TICKS_PER_PERIOD + 1) * SERVO_SPACING);
            measure_ratio(1'b1, measured);
            for (int ch = 0; ch < `SUB_MOTOR_COUNT; ch++) begin
                post_check(KIND_RATIO, $sformatf("servo %0d pass %0d", ch, pass),
                           expected_ratio(1'b1, ch), measured[ch]);
            end
        end

        // LED rule over all 16 combinations
        for (int v = 0; v < 16; v++) begin
            wr      = bus_pkg::reg_data_t'($random(seed));
            wr[3:0] = 4'(v);
            spi_write(`SUB_ADDR_LED, wr);
            wait_clocks(4);
            post_leds($sformatf("led 0x%h", v));
        end

        wait_clocks(3);                                             // Let the checker drain
        if (checks_done == checks_posted && kind_q.size() == 0 && checks_posted > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Only %0d of %0d checks were compared", checks_done, checks_posted);
            $display("TEST FAILED");
            $fatal(1, "comparisons missing at end of run");
        end
    end

    // Checker, drains posted results once per clock
    initial begin : compare_results
        int         kind;
        string      name;
        logic [7:0] exp_v;
        logic [7:0] act_v;
        forever begin
            @(posedge clock);
            while (kind_q.size() > 0) begin
                kind  = kind_q.pop_front();
                name  = name_q.pop_front();
                exp_v = exp_q.pop_front();
                act_v = act_q.pop_front();
                case (kind)
                    KIND_DATA:  check_data(name, exp_v, act_v);
                    KIND_RATIO: check_ratio(name, exp_v, act_v);
                    default:    check_level(name, exp_v[0], act_v[0]);
                endcase
                checks_done++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
+incdir+sim
logic/bus_pkg.sv
logic/motor_pkg.sv
logic/spi_target.sv
logic/reg_file.sv
logic/pwm_channel.sv
logic/fpga_subsystem.sv
sim/tb_fpga_subsystem.sv
